/* Makefile */
# Verilator build and run of the MICROROC front-end testbench

VERILATOR ?= verilator
TOP       ?= tb_microroc_daq
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^TESTS PASSED$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/microroc_defs.svh */
`ifndef MICROROC_DEFS_SVH
`define MICROROC_DEFS_SVH

//////////////////////////////
// widths
//////////////////////////////
`define MICROROC_CTRL_W      16   // one usb control word
`define MICROROC_DAC_W       10   // triple dac threshold
`define MICROROC_CHN         64   // channels per asic
`define MICROROC_HEADER_W    8    // chip header

// bits per asic in one daisy-chain frame
`define MICROROC_SC_FRAME_W  102  // header + 3 dacs + ctest
`define MICROROC_RR_FRAME_W  64   // read register

//////////////////////////////
// timing, in Clk cycles
//////////////////////////////
`define MICROROC_SR_HALF     2    // half period of SR_CK
`define MICROROC_RSTB_CYCLES 8    // SR_RSTB low pulse

// start_acq pattern
`define MICROROC_ACQ_GAP     8    // low time between pulses
`define MICROROC_ACQ_TIME_RST 7   // acq_time after reset, pulse is acq_time+1 long

`endif

/* rtl/acq_sequencer.sv */
`timescale 1ns/1ps

`include "microroc_defs.svh"

module acq_sequencer (
    input  logic       Clk,
    input  logic       reset,
    input  logic       acq_start,
    input  logic       acq_stop,
    input  logic [7:0] acq_time,   // pulse is acq_time+1 cycles
    output logic       start_acq
);

    logic       run;        // run active
    logic       acq_phase;  // 1 = start_acq high part
    logic [7:0] cnt;        // cycles left in this phase, minus one

    //////////////////////////////
    // run / phase / counter
    //////////////////////////////
    always_ff @(posedge Clk) begin
        if (reset) begin
            run       <= 1'b0;
            acq_phase <= 1'b0;
            cnt       <= '0;
        end else if (acq_stop) begin
            run       <= 1'b0;   // drops on the next edge
            acq_phase <= 1'b0;
        end else if (!run) begin
            if (acq_start) begin
                run       <= 1'b1;
                acq_phase <= 1'b1;
                cnt       <= acq_time;  // sampled per pulse
            end
        end else if (cnt != 8'd0) begin
            cnt <= cnt - 8'd1;
        end else if (acq_phase) begin
            // end of pulse, go to gap
            acq_phase <= 1'b0;
            cnt       <= 8'(`MICROROC_ACQ_GAP - 1);
        end else begin
            // end of gap, next pulse with current acq_time
            acq_phase <= 1'b1;
            cnt       <= acq_time;
        end
    end

    // start while running just falls into the run branch, ignored
    assign start_acq = acq_phase;

endmodule

/* rtl/ctrl_word_receiver.sv */
`timescale 1ns/1ps

module ctrl_word_receiver
    import microroc_pkg::*;
(
    input  logic       Clk,
    input  logic       reset,
    input  ctrl_fifo_t ctrl_fifo,
    input  logic       sr_busy,     // serializer shifting, hold the fifo
    output logic       ctrl_rd_en,
    output logic       wr_strobe,
    output ctrl_word_u wr_word,
    output load_req_t  load_req,
    output logic       acq_start,
    output logic       acq_stop
);

    ctrl_word_u word;
    logic       pop_hold;    // blocks the pop right after a load
    logic       is_write;
    logic       is_load;
    logic       load_valid;
    logic       load_sel;

    assign word = ctrl_fifo.dout;

    // fwft read, never while empty
    assign ctrl_rd_en = !ctrl_fifo.empty && !sr_busy && !pop_hold;

    //////////////////////////////
    // opcode decode
    //////////////////////////////
    assign is_write = word.reg_view.opcode inside {OP_CTEST, OP_READ_REG, OP_MISC, OP_DAC};
    assign is_load  = word.reg_view.opcode == OP_LOAD;

    // strobes, one cycle each
    always_ff @(posedge Clk) begin
        if (reset) begin
            wr_strobe  <= 1'b0;
            load_valid <= 1'b0;
            acq_start  <= 1'b0;
            acq_stop   <= 1'b0;
            pop_hold   <= 1'b1;  // nothing popped until out of reset
        end else begin
            wr_strobe  <= ctrl_rd_en && is_write;
            load_valid <= ctrl_rd_en && is_load;
            acq_start  <= ctrl_rd_en && (word.reg_view.opcode == OP_ACQ_START);
            acq_stop   <= ctrl_rd_en && (word.reg_view.opcode == OP_ACQ_STOP);
            pop_hold   <= ctrl_rd_en && is_load;  // sr_busy rises one edge later
        end
    end

    // payload of the popped word
    always_ff @(posedge Clk) begin
        if (ctrl_rd_en) begin
            wr_word  <= word;
            load_sel <= word.reg_view.value[0];
        end
    end

    assign load_req = '{valid: load_valid, sc_or_read: load_sel};

    // unknown opcodes fall through: popped, no strobe

endmodule

/* rtl/microroc_daq_top.sv */
`timescale 1ns/1ps

module microroc_daq_top
    import microroc_pkg::*;
(
    input  logic       Clk,
    input  logic       reset,
    input  ctrl_fifo_t ctrl_fifo,    // usb control fifo, fwft
    output logic       ctrl_rd_en,
    output sr_pins_t   sr,           // SELECT, SR_RSTB, SR_CK, SR_IN
    output logic       start_acq,
    output logic       config_done
);

    logic       wr_strobe;
    ctrl_word_u wr_word;
    load_req_t  load_req;
    logic       acq_start;
    logic       acq_stop;
    sc_params_t params;
    logic       sr_busy;

    //////////////////////////////
    // input side
    //////////////////////////////
    ctrl_word_receiver u_ctrl_word_receiver (
        .Clk        (Clk),
        .reset      (reset),
        .ctrl_fifo  (ctrl_fifo),
        .sr_busy    (sr_busy),
        .ctrl_rd_en (ctrl_rd_en),
        .wr_strobe  (wr_strobe),
        .wr_word    (wr_word),
        .load_req   (load_req),
        .acq_start  (acq_start),
        .acq_stop   (acq_stop)
    );

    // parameter registers
    param_bank u_param_bank (
        .Clk       (Clk),
        .reset     (reset),
        .wr_strobe (wr_strobe),
        .wr_word   (wr_word),
        .params    (params)
    );

    acq_sequencer u_acq_sequencer (
        .Clk       (Clk),
        .reset     (reset),
        .acq_start (acq_start),
        .acq_stop  (acq_stop),
        .acq_time  (params.acq_time),
        .start_acq (start_acq)      // START_ACQ pin
    );

    //////////////////////////////
    // asic daisy chain
    //////////////////////////////
    sr_serializer u_sr_serializer (
        .Clk         (Clk),
        .reset       (reset),
        .load_req    (load_req),
        .params      (params),
        .sr          (sr),
        .sr_busy     (sr_busy),     // back-pressure to the receiver
        .config_done (config_done)
    );

endmodule

/* rtl/microroc_pkg.sv */
package microroc_pkg;

`include "microroc_defs.svh"

    //////////////////////////////
    // usb control words
    //////////////////////////////
    typedef enum logic [3:0] {
        OP_CTEST     = 4'd1,  // ctest byte
        OP_READ_REG  = 4'd2,  // read register byte
        OP_MISC      = 4'd3,  // header, asic_num, acq_time
        OP_DAC       = 4'd4,  // one of the 10-bit thresholds
        OP_LOAD      = 4'd5,  // shift a frame into the chain
        OP_ACQ_START = 4'd6,
        OP_ACQ_STOP  = 4'd7
    } opcode_e;

    // same 16 bits, byte-register layout or dac layout
    typedef union packed {
        struct packed {
            opcode_e    opcode;
            logic [3:0] addr;
            logic [7:0] value;
        } reg_view;
        struct packed {
            opcode_e                   opcode;
            logic [`MICROROC_DAC_W-1:0] dac_value;
            logic [1:0]                dac_sel;   // 3 is unused
        } dac_view;
    } ctrl_word_u;

    // fwft fifo, dout valid while empty is low
    typedef struct packed {
        logic                        empty;
        logic [`MICROROC_CTRL_W-1:0] dout;
    } ctrl_fifo_t;

    typedef struct packed {
        logic [`MICROROC_HEADER_W-1:0] header;
        logic [`MICROROC_DAC_W-1:0]    dac2;
        logic [`MICROROC_DAC_W-1:0]    dac1;
        logic [`MICROROC_DAC_W-1:0]    dac0;
        logic [`MICROROC_CHN-1:0]      ctest;
        logic [`MICROROC_CHN-1:0]      read_reg;
        logic [2:0]                    asic_num;   // chain length minus one
        logic [7:0]                    acq_time;
    } sc_params_t;

    typedef struct packed {
        logic valid;
        logic sc_or_read;  // 1 = slow control, 0 = read register
    } load_req_t;

    // asic slow-control pins
    typedef struct packed {
        logic select;
        logic sr_rstb;
        logic sr_ck;
        logic sr_in;
    } sr_pins_t;

endpackage

/* rtl/param_bank.sv */
`timescale 1ns/1ps

`include "microroc_defs.svh"

module param_bank
    import microroc_pkg::*;
(
    input  logic       Clk,
    input  logic       reset,
    input  logic       wr_strobe,
    input  ctrl_word_u wr_word,
    output sc_params_t params
);

    logic [3:0] addr;
    logic [7:0] value;
    logic       byte_ok;    // addr 0..7 hits a byte of a 64-bit register
    logic [5:0] byte_lsb;   // lsb of the addressed byte

    assign addr     = wr_word.reg_view.addr;
    assign value    = wr_word.reg_view.value;
    assign byte_ok  = !addr[3];
    assign byte_lsb = {addr[2:0], 3'b000};

    //////////////////////////////
    // register writes
    //////////////////////////////
    always_ff @(posedge Clk) begin
        if (reset) begin
            params          <= '0;
            params.acq_time <= `MICROROC_ACQ_TIME_RST;
        end else if (wr_strobe) begin
            case (wr_word.reg_view.opcode)
                // byte 0 is bits 7..0
                OP_CTEST: begin
                    if (byte_ok) begin
                        params.ctest[byte_lsb +: 8] <= value;
                    end
                end
                OP_READ_REG: begin
                    if (byte_ok) begin
                        params.read_reg[byte_lsb +: 8] <= value;
                    end
                end
                OP_MISC: begin
                    case (addr)
                        4'd0:    params.header   <= value;
                        4'd1:    params.asic_num <= value[2:0];  // up to 8 chips
                        4'd2:    params.acq_time <= value;
                        default: ;                               // out of range
                    endcase
                end
                // dac view of the same word
                OP_DAC: begin
                    case (wr_word.dac_view.dac_sel)
                        2'd0:    params.dac0 <= wr_word.dac_view.dac_value;
                        2'd1:    params.dac1 <= wr_word.dac_view.dac_value;
                        2'd2:    params.dac2 <= wr_word.dac_view.dac_value;
                        default: ;  // sel 3 ignored
                    endcase
                end
                default: ;  // load and run control handled elsewhere
            endcase
        end
    end

    // frames are assembled in the serializer from these fields
    // header, dac2, dac1, dac0, ctest for slow control
    // read_reg alone for the read register

endmodule

/* rtl/sr_serializer.sv */
`timescale 1ns/1ps

`include "microroc_defs.svh"

module sr_serializer
    import microroc_pkg::*;
(
    input  logic       Clk,
    input  logic       reset,
    input  load_req_t  load_req,
    input  sc_params_t params,
    output sr_pins_t   sr,
    output logic       sr_busy,
    output logic       config_done
);

    localparam int SC_W = `MICROROC_SC_FRAME_W;
    localparam int RR_W = `MICROROC_RR_FRAME_W;
    localparam int PH_N = 2 * `MICROROC_SR_HALF;   // Clk cycles per bit
    localparam int PH_W = $clog2(PH_N);

    typedef enum logic [1:0] {S_IDLE, S_RSTB, S_SHIFT, S_DONE} state_e;

    state_e          state;
    logic [SC_W-1:0] sc_frame;
    logic [SC_W-1:0] rr_frame;   // left aligned, tail unused
    logic [SC_W-1:0] frame_q;    // per-asic frame, reloaded at each chip
    logic [SC_W-1:0] sreg;       // msb is the next bit out
    logic [6:0]      bit_cnt;    // bits left after current, rstb wait in S_RSTB
    logic [6:0]      last_bit;
    logic [2:0]      asic_cnt;   // chips left after current
    logic [PH_W-1:0] ph;         // SR_CK phase within a bit
    logic            ph_last;
    logic            accept;
    logic            shift_bit;  // next bit from sreg
    logic            next_asic;  // restart from frame_q

    //////////////////////////////
    // frame assembly, msb first
    //////////////////////////////
    assign sc_frame = {params.header, params.dac2, params.dac1, params.dac0, params.ctest};
    assign rr_frame = {params.read_reg, {(SC_W - RR_W){1'b0}}};

    assign last_bit = sr.select ? 7'(SC_W - 1) : 7'(RR_W - 1);
    assign ph_last  = ph == PH_W'(PH_N - 1);

    assign accept    = load_req.valid && (state == S_IDLE || state == S_DONE);
    assign shift_bit = (state == S_RSTB && bit_cnt == 7'd0)
                    || (state == S_SHIFT && ph_last && bit_cnt != 7'd0);
    assign next_asic = state == S_SHIFT && ph_last && bit_cnt == 7'd0 && asic_cnt != 3'd0;

    // frame data
    always_ff @(posedge Clk) begin
        if (accept) begin
            frame_q <= load_req.sc_or_read ? sc_frame : rr_frame;
            sreg    <= load_req.sc_or_read ? sc_frame : rr_frame;
        end else if (shift_bit) begin
            sreg <= sreg << 1;
        end else if (next_asic) begin
            sreg <= frame_q << 1;   // first bit goes out now
        end
    end

    //////////////////////////////
    // fsm and pins
    //////////////////////////////
    always_ff @(posedge Clk) begin
        if (reset) begin
            state       <= S_IDLE;
            sr.select   <= 1'b0;
            sr.sr_rstb  <= 1'b1;
            sr.sr_ck    <= 1'b0;
            sr.sr_in    <= 1'b0;
            sr_busy     <= 1'b0;
            config_done <= 1'b0;
            bit_cnt     <= '0;
            asic_cnt    <= '0;
            ph          <= '0;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    config_done <= 1'b0;   // single cycle
                    state       <= S_IDLE;
                    if (accept) begin
                        state      <= S_RSTB;
                        sr_busy    <= 1'b1;
                        sr.select  <= load_req.sc_or_read;
                        sr.sr_rstb <= 1'b0;
                        bit_cnt    <= 7'(`MICROROC_RSTB_CYCLES - 1);
                        asic_cnt   <= params.asic_num;
                    end
                end
                S_RSTB: begin
                    if (bit_cnt != 7'd0) begin
                        bit_cnt <= bit_cnt - 7'd1;
                    end else begin
                        sr.sr_rstb <= 1'b1;
                        sr.sr_in   <= sreg[SC_W-1];  // first bit
                        bit_cnt    <= last_bit;
                        ph         <= '0;
                        state      <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    if (!ph_last) begin
                        ph       <= ph + 1'b1;
                        sr.sr_ck <= (int'(ph) + 1 >= `MICROROC_SR_HALF);  // high in 2nd half
                    end else begin
                        ph       <= '0;
                        sr.sr_ck <= 1'b0;      // data changes with ck low
                        if (shift_bit) begin
                            bit_cnt  <= bit_cnt - 7'd1;
                            sr.sr_in <= sreg[SC_W-1];
                        end else if (next_asic) begin
                            asic_cnt <= asic_cnt - 3'd1;
                            bit_cnt  <= last_bit;
                            sr.sr_in <= frame_q[SC_W-1];
                        end else begin
                            // last bit of last chip done
                            sr.sr_in    <= 1'b0;
                            sr_busy     <= 1'b0;
                            config_done <= 1'b1;
                            state       <= S_DONE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* tb.f */
+incdir+include
rtl/microroc_pkg.sv
rtl/ctrl_word_receiver.sv
rtl/param_bank.sv
rtl/acq_sequencer.sv
rtl/sr_serializer.sv
rtl/microroc_daq_top.sv
testbench/tb_clk_gen.sv
testbench/tb_microroc_daq.sv

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic Clk,
    output logic reset
);

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;   // 10 ns period
    end

    // high over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge Clk);
        #1 reset = 1'b0;
    end

endmodule

/* testbench/tb_microroc_daq.sv */
`timescale 1ns/1ps

`include "microroc_defs.svh"

module tb_microroc_daq
    import microroc_pkg::*;
();

    localparam int ROUNDS   = 3;   // three loads per round
    localparam int LOAD_MAX = `MICROROC_RSTB_CYCLES + 4 * 4 * `MICROROC_SC_FRAME_W;
    localparam int ACQ_LEN  = 300;
    localparam int TIMEOUT  = 4 * (ROUNDS * 3 * LOAD_MAX + ACQ_LEN);

    logic        Clk;
    logic        reset;
    ctrl_fifo_t  ctrl_fifo = '{empty: 1'b1, dout: '0};
    logic        ctrl_rd_en;
    sr_pins_t    sr;
    logic        start_acq;
    logic        config_done;

    logic [15:0] fifo_q[$];      // fwft contents, front is dout
    logic        exp_bits[$];    // chain bits still to come
    int          exp_n = 0;
    logic        exp_select = 1'b0;
    logic        load_active = 1'b0;
    int          cycle = 0;
    int          check_errors = 0;
    int          other_errors = 0;

    // reference parameters, updated as words are consumed
    logic [7:0]  m_header = '0;
    logic [9:0]  m_dac0 = '0;
    logic [9:0]  m_dac1 = '0;
    logic [9:0]  m_dac2 = '0;
    logic [63:0] m_ctest = '0;
    logic [63:0] m_read_reg = '0;
    logic [2:0]  m_asic_num = '0;
    logic [7:0]  m_acq_time = 8'(`MICROROC_ACQ_TIME_RST);
    logic [7:0]  acq_time_lag = 8'(`MICROROC_ACQ_TIME_RST);  // as seen by the dut
    logic [7:0]  acq_sample = 8'(`MICROROC_ACQ_TIME_RST);
    logic        m_run = 1'b0;
    int          acq_on_cyc = -1;   // edge where START_ACQ must rise
    int          stop_cyc = 0;

    // pin monitor state
    logic        prev_rstb = 1'b1;
    logic        prev_ck = 1'b0;
    logic        prev_acq = 1'b0;
    logic        lo_valid = 1'b0;
    int          accept_cyc = 0;
    int          rstb_low = 0;
    int          hi_cnt = 0;
    int          hi_exp = 0;
    int          lo_cnt = 0;

    tb_clk_gen u_tb_clk_gen (.Clk(Clk), .reset(reset));

    microroc_daq_top u_microroc_daq_top (
        .Clk         (Clk),
        .reset       (reset),
        .ctrl_fifo   (ctrl_fifo),
        .ctrl_rd_en  (ctrl_rd_en),
        .sr          (sr),
        .start_acq   (start_acq),
        .config_done (config_done)
    );

    function automatic void flag_mismatch(input string msg);
        check_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endfunction

    function automatic void note_fault(input string msg);
        other_errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endfunction

    function automatic logic [15:0] reg_word(input logic [3:0] op, input logic [3:0] addr,
                                             input logic [7:0] val);
        return {op, addr, val};
    endfunction

    function automatic logic [15:0] dac_word(input logic [1:0] sel, input logic [9:0] val);
        return {4'd4, val, sel};
    endfunction

    // expected chain bits, msb first per asic
    function automatic void queue_frame(input logic sc);
        for (int a = 0; a <= int'(m_asic_num); a++) begin
            if (sc) begin
                for (int i = 7; i >= 0; i--) exp_bits.push_back(m_header[i]);
                for (int i = 9; i >= 0; i--) exp_bits.push_back(m_dac2[i]);
                for (int i = 9; i >= 0; i--) exp_bits.push_back(m_dac1[i]);
                for (int i = 9; i >= 0; i--) exp_bits.push_back(m_dac0[i]);
                for (int i = 63; i >= 0; i--) exp_bits.push_back(m_ctest[i]);
            end else begin
                for (int i = 63; i >= 0; i--) exp_bits.push_back(m_read_reg[i]);
            end
        end
        exp_n       = exp_bits.size();
        exp_select  = sc;
        load_active = 1'b1;
    endfunction

    function automatic void apply_word(input logic [15:0] w);
        logic [3:0] op;
        logic [3:0] addr;
        logic [7:0] val;
        op   = w[15:12];
        addr = w[11:8];
        val  = w[7:0];
        case (op)
            4'd1: if (addr < 4'd8) m_ctest[int'(addr) * 8 +: 8] = val;
            4'd2: if (addr < 4'd8) m_read_reg[int'(addr) * 8 +: 8] = val;
            4'd3: begin
                if (addr == 4'd0) m_header = val;
                if (addr == 4'd1) m_asic_num = val[2:0];
                if (addr == 4'd2) m_acq_time = val;
            end
            4'd4: begin
                if (w[1:0] == 2'd0) m_dac0 = w[11:2];
                if (w[1:0] == 2'd1) m_dac1 = w[11:2];
                if (w[1:0] == 2'd2) m_dac2 = w[11:2];
            end
            4'd5: queue_frame(val[0]);
            4'd6: if (!m_run) begin
                m_run      = 1'b1;
                acq_on_cyc = cycle + 1;
                lo_valid   = 1'b0;    // first pulse has no gap before it
            end
            4'd7: begin
                m_run    = 1'b0;
                stop_cyc = cycle + 1;
            end
            default: ;                // unknown, dropped
        endcase
    endfunction

    //////////////////////////////
    // fifo model and cycle count
    //////////////////////////////
    always @(posedge Clk) begin : cycle_count
        cycle++;
        if (cycle > TIMEOUT) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    always @(posedge Clk) begin : fifo_model
        logic consume;
        consume      = ctrl_rd_en && !ctrl_fifo.empty;
        acq_sample   = acq_time_lag;   // value the dut samples at this edge
        acq_time_lag = m_acq_time;
        #1;
        if (consume) begin
            if (fifo_q.size() == 0) note_fault("word consumed from an empty fifo model");
            else apply_word(fifo_q.pop_front());
        end
        ctrl_fifo.empty = (fifo_q.size() == 0);
        ctrl_fifo.dout  = (fifo_q.size() == 0) ? 16'h0000 : fifo_q[0];
    end

    //////////////////////////////
    // assertions
    //////////////////////////////
    assert property (@(posedge Clk) ctrl_fifo.empty |-> !ctrl_rd_en)
        else flag_mismatch("ctrl_rd_en high while the fifo is empty");
    assert property (@(posedge Clk) config_done |=> !config_done)
        else flag_mismatch("config_done longer than one cycle");
    assert property (@(posedge Clk)
        reset |=> (sr == 4'b0100 && !start_acq && !config_done && !ctrl_rd_en))
        else flag_mismatch("outputs not at reset values during reset");

    always @(negedge Clk) begin : pin_monitor
        if (!reset) begin
            if (!sr.sr_rstb && prev_rstb) begin
                accept_cyc = cycle;     // load accepted on this edge
                rstb_low   = 0;
            end
            if (!sr.sr_rstb) rstb_low++;
            if (sr.sr_rstb && !prev_rstb) begin
                assert (rstb_low == `MICROROC_RSTB_CYCLES)
                    else flag_mismatch($sformatf("SR_RSTB low for %0d cycles", rstb_low));
            end
            // asic samples SR_IN on SR_CK rise
            if (sr.sr_ck && !prev_ck) begin
                if (exp_bits.size() == 0) begin
                    note_fault("SR_CK rose with no frame bit expected");
                end else begin
                    assert (sr.sr_in === exp_bits[0] && sr.select === exp_select)
                        else flag_mismatch($sformatf("bit %0d SR_IN %b SELECT %b, expected %b %b",
                            exp_n - exp_bits.size(), sr.sr_in, sr.select, exp_bits[0],
                            exp_select));
                    void'(exp_bits.pop_front());
                end
            end
            if (config_done) begin
                if (!load_active) begin
                    note_fault("config_done with no load in progress");
                end else begin
                    assert (exp_bits.size() == 0)
                        else flag_mismatch($sformatf("%0d bits missing", exp_bits.size()));
                    assert (cycle - accept_cyc == `MICROROC_RSTB_CYCLES + 4 * exp_n)
                        else flag_mismatch($sformatf("config_done %0d cycles after accept",
                            cycle - accept_cyc));
                    load_active = 1'b0;
                end
            end else if (load_active) begin
                assert (!ctrl_rd_en) else flag_mismatch("control word popped during a load");
            end

            // START_ACQ pattern
            if (cycle == acq_on_cyc) begin
                assert (start_acq) else flag_mismatch("START_ACQ did not rise after start");
            end
            if (!m_run && cycle >= stop_cyc) begin
                assert (!start_acq) else flag_mismatch("START_ACQ high with no run active");
            end
            if (m_run) begin
                if (start_acq && !prev_acq) begin
                    if (lo_valid) begin
                        assert (lo_cnt == `MICROROC_ACQ_GAP)
                            else flag_mismatch($sformatf("START_ACQ gap %0d cycles", lo_cnt));
                    end
                    hi_cnt = 1;
                    hi_exp = int'(acq_sample) + 1;
                end else if (start_acq) begin
                    hi_cnt++;
                end else if (prev_acq) begin
                    assert (hi_cnt == hi_exp)
                        else flag_mismatch($sformatf("START_ACQ pulse %0d cycles, expected %0d",
                            hi_cnt, hi_exp));
                    lo_cnt   = 1;
                    lo_valid = 1'b1;
                end else begin
                    lo_cnt++;
                end
            end
            prev_rstb = sr.sr_rstb;
            prev_ck   = sr.sr_ck;
            prev_acq  = start_acq;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    task automatic send_word(input logic [15:0] w);
        repeat ($urandom_range(0, 3)) @(negedge Clk);   // idle gap
        @(negedge Clk);
        fifo_q.push_back(w);
    endtask

    task automatic wait_idle();
        while (fifo_q.size() != 0 || load_active) @(negedge Clk);
    endtask

    task automatic run_load_round();
        send_word(reg_word(4'd3, 4'd0, 8'($urandom)));             // header
        for (int d = 0; d < 3; d++) send_word(dac_word(2'(d), 10'($urandom)));
        for (int b = 0; b < 8; b++) begin
            send_word(reg_word(4'd1, 4'(b), 8'($urandom)));
            send_word(reg_word(4'd2, 4'(b), 8'($urandom)));
        end
        send_word(reg_word(4'd3, 4'd1, 8'($urandom_range(0, 3)))); // asic_num
        send_word(reg_word(4'd5, 4'd0, 8'd1));                     // slow-control load
        // queued behind the load
        send_word(dac_word(2'($urandom_range(0, 2)), 10'($urandom)));
        send_word(reg_word(4'($urandom_range(8, 15)), 4'd0, 8'($urandom)));
        send_word(dac_word(2'd3, 10'($urandom)));
        send_word(reg_word(4'd3, 4'd9, 8'($urandom)));
        send_word(reg_word(4'd1, 4'd12, 8'($urandom)));
        send_word(reg_word(4'd5, 4'd0, 8'd0));                     // read-register load
        wait_idle();
        send_word(reg_word(4'd5, 4'd0, 8'd1));   // new dac in this frame
        wait_idle();
    endtask

    task automatic run_acquisition();
        send_word(reg_word(4'd3, 4'd2, 8'($urandom_range(0, 10))));
        send_word(reg_word(4'd6, 4'd0, 8'd0));
        repeat (70) @(negedge Clk);
        send_word(reg_word(4'd3, 4'd2, 8'($urandom_range(0, 10))));
        send_word(reg_word(4'd6, 4'd0, 8'd0));   // ignored, already running
        repeat (70) @(negedge Clk);
        send_word(reg_word(4'd7, 4'd0, 8'd0));
        repeat (30) @(negedge Clk);
        send_word(reg_word(4'd6, 4'd0, 8'd0));
        repeat (40) @(negedge Clk);
        send_word(reg_word(4'd7, 4'd0, 8'd0));
        repeat (20) @(negedge Clk);
    endtask

    initial begin : stimulus
        void'($urandom(32'hed993550));
        @(negedge Clk);
        while (reset) @(negedge Clk);
        assert (sr == 4'b0100 && !config_done && !start_acq && !ctrl_rd_en)
            else flag_mismatch("outputs not at reset values after reset");
        for (int r = 0; r < ROUNDS; r++) run_load_round();
        run_acquisition();
        repeat (4) @(negedge Clk);
        if (exp_bits.size() != 0 || load_active) note_fault("a load never finished");
        $display("errors: %0d check, %0d other", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
